/* tests/memmap_golden.txt */
# kind addr data valid rom we fetch phys_addr dos
# kind P port write, M read, F opcode fetch, W write; P lines check dos only
M 0123 00 1 1 0 0 00123 0
M 4567 00 1 0 0 0 14567 0
M 8abc 00 1 0 0 0 08abc 0
M c001 00 1 0 0 0 00001 0
P 7ffd 13 0 0 0 0 00000 0
M c100 00 1 0 0 0 0c100 0
M 0200 00 1 1 0 0 04200 0
P 7ffd 06 0 0 0 0 00000 0
M c000 00 1 0 0 0 18000 0
M 3d10 00 1 1 0 0 03d10 0
F 3d2f 00 1 1 0 1 03d2f 1
M 0040 00 1 1 0 0 08040 1
F 8000 00 1 0 0 1 08000 0
M 0040 00 1 1 0 0 00040 0
W 1234 55 1 1 0 0 01234 0
W 5678 aa 1 0 1 0 15678 0
P eff7 04 0 0 0 0 00000 0
W 1234 5a 1 1 1 0 01234 0
P 0077 01 0 0 0 0 00000 0
P 3ff7 fe 0 0 0 0 00000 0
P 7ff7 7a 0 0 0 0 00000 0
P bff7 c0 0 0 0 0 00000 0
P fff7 f5 0 0 0 0 00000 0
M 0100 00 1 0 0 0 04100 0
M 4100 00 1 1 0 0 14100 0
M 8100 00 1 0 0 0 fc100 0
M c100 00 1 0 0 0 28100 0
P 7ffd 07 0 0 0 0 00000 0
M c100 00 1 0 0 0 28100 0
P 0077 00 0 0 0 0 00000 0
M c100 00 1 0 0 0 1c100 0
P 7ffd 21 0 0 0 0 00000 0
M c100 00 1 0 0 0 04100 0
P 7ffd 03 0 0 0 0 00000 0
M c100 00 1 0 0 0 04100 0

/* sources.f */
+incdir+logic
logic/memmap_pkg.sv
logic/zbus_ctrl.sv
logic/atm_pager.sv
logic/mem_addr_mux.sv
logic/memmap_top.sv
tests/tb_clock.sv
tests/memmap_props.sv
tests/memmap_tb.sv

/* Makefile */
TOP := memmap_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* tests/memmap_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module memmap_tb
	import memmap_pkg::*;
();

	localparam int    RESET_CYCLES = 10;
	localparam int    MARGIN       = 20;
	localparam string GOLDEN       = "tests/memmap_golden.txt";

	logic      fclk;
	logic      rst_n;
	zbus_req_t req;
	mem_acc_t  acc;
	logic      dos;

	// golden lines, one entry per bus cycle
	byte       kinds [$];
	zbus_req_t reqs [$];
	mem_acc_t  exp_acc [$];
	logic      exp_dos [$];

	int        cycles = 0;
	int        limit = 0;

	tb_clock u_clock
	(
		.fclk  (fclk),
		.rst_n (rst_n)
	);

	memmap_top dut0
	(
		.fclk  (fclk),
		.rst_n (rst_n),
		.req   (req),
		.acc   (acc),
		.dos   (dos)
	);

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	function automatic zbus_req_t make_req(byte kind, zaddr_t addr, zdata_t data);
		zbus_req_t r;
		r      = '0;
		r.addr = addr;
		r.data = data;
		case (kind)
			"P":
			begin
				r.iorq = 1'b1;
				r.wr   = 1'b1;
			end
			"F":
			begin
				r.mreq = 1'b1;
				r.rd   = 1'b1;
				r.m1   = 1'b1;
			end
			"W":
			begin
				r.mreq = 1'b1;
				r.wr   = 1'b1;
			end
			default:
			begin
				r.mreq = 1'b1;
				r.rd   = 1'b1;
			end
		endcase
		return r;
	endfunction

	// bus idle, address and data left floating
	task automatic drive_idle();
		zbus_req_t r;
		r      = '0;
		r.addr = zaddr_t'($urandom());
		r.data = zdata_t'($urandom());
		req   <= r;
	endtask

	task automatic load_golden();
		int         fd;
		int         n;
		string      line;
		byte        kind;
		zaddr_t     addr;
		zdata_t     data;
		logic       v;
		logic       rom;
		logic       we;
		logic       fetch;
		phys_addr_t paddr;
		logic       ds;
		mem_acc_t   e;
		fd = $fopen(GOLDEN, "r");
		if (fd == 0)
		begin
			$display("could not open the golden file %s", GOLDEN);
			$display("Test failed");
			$fatal(1, "golden file missing");
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() > 1 && line.getc(0) != "#")
				begin
					n = $sscanf(line, "%c %h %h %h %h %h %h %h %h",
						kind, addr, data, v, rom, we, fetch, paddr, ds);
					if (n != 9 || !(kind inside {"P", "M", "F", "W"}))
					begin
						$display("golden file has a line that cannot be read: %s", line);
						$display("Test failed");
						$fatal(1, "bad golden line");
					end
					else
					begin
						e.valid = v;
						e.rom   = rom;
						e.we    = we;
						e.fetch = fetch;
						e.addr  = paddr;
						kinds.push_back(kind);
						reqs.push_back(make_req(kind, addr, data));
						exp_acc.push_back(e);
						exp_dos.push_back(ds);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_acc(input int idx, input mem_acc_t got, input mem_acc_t exp);
		string field;
		field = "";
		if (got.addr !== exp.addr)
			field = "addr";
		if (got.fetch !== exp.fetch)
			field = "fetch";
		if (got.we !== exp.we)
			field = "we";
		if (got.rom !== exp.rom)
			field = "rom";
		if (got.valid !== exp.valid)
			field = "valid";
		if (field != "")
		begin
			$display("Mismatch at %0t: line %0d acc.%s got %h expected %h",
				$time, idx, field, got, exp);
			$display("Test failed");
			$fatal(1, "acc mismatch");
		end
	endtask

	task automatic check_dos(input int idx, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: line %0d dos got %b expected %b",
				$time, idx, got, exp);
			$display("Test failed");
			$fatal(1, "dos mismatch");
		end
	endtask

	//////////////////////////////
	// run limit
	//////////////////////////////

	always @(posedge fclk)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
		begin
			$display("run did not finish within %0d cycles", limit);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		req = '0;
		void'($urandom(32'h588f3841));
		load_golden();
		limit = RESET_CYCLES + 2 * kinds.size() + MARGIN;

		wait (rst_n === 1'b1);
		for (int i = 0; i < kinds.size(); i++)
		begin
			@(posedge fclk);
			req <= reqs[i];
			@(posedge fclk);
			drive_idle();
			// acc and dos are settled by the falling edge
			@(negedge fclk);
			if (kinds[i] != "P")
				check_acc(i, acc, exp_acc[i]);
			check_dos(i, dos, exp_dos[i]);
		end

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/memmap_props.sv */
`timescale 1ns/1ps
`default_nettype none

module memmap_props
	import memmap_pkg::*;
(
	input logic      fclk,
	input logic      rst_n,
	input zbus_req_t req,
	input map_cfg_t  cfg,
	input mem_acc_t  acc
);

	//////////////////////////////
	// output stage sanity
	//////////////////////////////

	a_we_needs_valid : assert property (@(posedge fclk) disable iff (!rst_n)
		acc.we |-> acc.valid)
		else $error("acc.we raised without acc.valid");

	// acc lags the bus by one cycle
	a_valid_from_mreq : assert property (@(posedge fclk) disable iff (!rst_n)
		acc.valid |-> $past(req.mreq && (req.rd || req.wr)))
		else $error("acc.valid without a memory request one cycle before");

	// protected rom stays read only
	a_rom_wr_protect : assert property (@(posedge fclk) disable iff (!rst_n)
		(acc.we && acc.rom) |-> $past(cfg.rom_we_en))
		else $error("rom write enabled while eff7 write enable was low");

endmodule

bind memmap_top memmap_props u_props
(
	.fclk  (fclk),
	.rst_n (rst_n),
	.req   (req),
	.cfg   (cfg),
	.acc   (acc)
);

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
	output logic fclk,
	output logic rst_n
);

	// 10 ns period
	initial
	begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (10) @(posedge fclk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* logic/memmap_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memmap_settings.svh"

module memmap_top
	import memmap_pkg::*;
(
	input  logic      fclk,
	input  logic      rst_n,

	input  zbus_req_t req,

	output mem_acc_t  acc,
	output logic      dos
);

	map_cfg_t cfg;
	page_wr_t pg_wr;
	win_map_t maps [`MM_WINDOWS];

	//////////////////////////////
	// bus decoder
	//////////////////////////////

	zbus_ctrl u_zbus_ctrl
	(
		.fclk     (fclk),
		.rst_n    (rst_n),
		.req      (req),
		.win0_rom (maps[0].rom),
		.cfg      (cfg),
		.pg_wr    (pg_wr)
	);

	//////////////////////////////
	// window pagers
	//////////////////////////////

	for (genvar i = 0; i < `MM_WINDOWS; i++)
	begin : g_pager
		atm_pager #(.WIN(i)) u_pager
		(
			.fclk  (fclk),
			.rst_n (rst_n),
			.cfg   (cfg),
			.pg_wr (pg_wr),
			.map   (maps[i])
		);
	end

	//////////////////////////////
	// physical address
	//////////////////////////////

	mem_addr_mux u_mem_addr_mux
	(
		.fclk  (fclk),
		.rst_n (rst_n),
		.req   (req),
		.cfg   (cfg),
		.maps  (maps),
		.acc   (acc)
	);

	assign dos = cfg.dos;

endmodule

`default_nettype wire

/* logic/mem_addr_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memmap_settings.svh"

module mem_addr_mux
	import memmap_pkg::*;
(
	input  logic      fclk,
	input  logic      rst_n,

	input  zbus_req_t req,
	input  map_cfg_t  cfg,
	input  win_map_t  maps [`MM_WINDOWS],

	output mem_acc_t  acc
);

	win_idx_t   win;
	win_map_t   sel;

	logic       nxt_valid;
	logic       nxt_we;
	phys_addr_t nxt_addr;

	logic       acc_valid;
	logic       acc_we;
	logic       acc_rom;
	logic       acc_fetch;
	phys_addr_t acc_addr;

	//////////////////////////////
	// window select
	//////////////////////////////

	always_comb
	begin
		win = req.addr[15:14];
		sel = maps[win];
	end

	always_comb
	begin
		nxt_valid = req.mreq & (req.rd | req.wr);

		// rom writes need the eff7 enable
		nxt_we    = nxt_valid & req.wr & (~sel.rom | cfg.rom_we_en);

		nxt_addr  = {sel.page, req.addr[`MM_OFFS_W-1:0]};
	end

	//////////////////////////////
	// output stage
	//////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			acc_valid <= 1'b0;
			acc_we    <= 1'b0;
		end
		else
		begin
			acc_valid <= nxt_valid;
			acc_we    <= nxt_we;
		end
	end

	always_ff @(posedge fclk)
	begin
		acc_rom   <= sel.rom;
		acc_fetch <= req.m1;
		acc_addr  <= nxt_addr;
	end

	always_comb
	begin
		acc.valid = acc_valid;
		acc.rom   = acc_rom;
		acc.we    = acc_we;
		acc.fetch = acc_fetch;
		acc.addr  = acc_addr;
	end

endmodule

`default_nettype wire

/* logic/atm_pager.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memmap_settings.svh"

module atm_pager
	import memmap_pkg::*;
#(
	parameter int WIN = 0
)
(
	input  logic     fclk,
	input  logic     rst_n,

	input  map_cfg_t cfg,
	input  page_wr_t pg_wr,

	output win_map_t map
);

	localparam win_idx_t MY_WIN = win_idx_t'(WIN);

	logic     wr_hit;
	win_map_t stored;
	win_map_t paged;
	win_map_t fallback;

	assign wr_hit = pg_wr.valid && (pg_wr.win == MY_WIN);

	//////////////////////////////
	// atm page register
	//////////////////////////////

	// comes out of reset mapping rom page 0
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			stored.rom  <= 1'b1;
			stored.page <= '0;
		end
		else if (wr_hit)
		begin
			stored.rom  <= pg_wr.rom;
			stored.page <= pg_wr.page;
		end
	end

	// forward a pending write so it counts from the next request
	always_comb
	begin
		if (wr_hit)
		begin
			paged.rom  = pg_wr.rom;
			paged.page = pg_wr.page;
		end
		else
			paged = stored;
	end

	//////////////////////////////
	// pentagon fallback
	//////////////////////////////

	always_comb
	begin
		case (WIN)
			0:
			begin
				// dos picks the upper rom pair
				fallback.rom  = 1'b1;
				fallback.page = {{(`MM_PAGE_W-2){1'b0}}, cfg.dos, cfg.p7ffd[4]};
			end
			1:
			begin
				fallback.rom  = 1'b0;
				fallback.page = page_t'(`MM_FB_PAGE_WIN1);
			end
			2:
			begin
				fallback.rom  = 1'b0;
				fallback.page = page_t'(`MM_FB_PAGE_WIN2);
			end
			default:
			begin
				fallback.rom  = 1'b0;
				fallback.page = {{(`MM_PAGE_W-3){1'b0}}, cfg.p7ffd[2:0]};
			end
		endcase
	end

	assign map = cfg.pager_en ? paged : fallback;

endmodule

`default_nettype wire

/* logic/zbus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memmap_settings.svh"

module zbus_ctrl
	import memmap_pkg::*;
(
	input  logic      fclk,
	input  logic      rst_n,

	input  zbus_req_t req,
	input  logic      win0_rom,

	output map_cfg_t  cfg,
	output page_wr_t  pg_wr
);

	zaddr_t     a;

	logic       io_wr;
	logic       hit_7ffd;
	logic       hit_eff7;
	logic       hit_77;
	logic       hit_f7;

	logic       m1_fetch;
	logic       dos_set;
	logic       dos_clr;

	zdata_t     p7ffd;
	logic       rom_we_en;
	logic       pager_en;

	dos_state_t dos_state;
	dos_state_t dos_next;

	logic       wr_valid;
	win_idx_t   wr_win;
	logic       wr_rom;
	page_t      wr_page;

	assign a = req.addr;

	//////////////////////////////
	// port decode
	//////////////////////////////

	always_comb
	begin
		io_wr    = req.iorq & req.wr;

		hit_7ffd = io_wr && (a[7:0] == `MM_PORT_7FFD_LO) && !a[15];
		hit_eff7 = io_wr && (a == `MM_PORT_EFF7);
		hit_77   = io_wr && (a[7:0] == `MM_PORT_77_LO);

		// xxF7 with a13..a8 all set, window from a15..a14
		hit_f7   = io_wr && (a[7:0] == `MM_PORT_F7_LO) && (&a[13:8]);
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			p7ffd     <= '0;
			rom_we_en <= 1'b0;
			pager_en  <= 1'b0;
		end
		else
		begin
			// once locked, 7ffd stays until reset
			if (hit_7ffd && !p7ffd[`MM_7FFD_LOCK])
				p7ffd <= req.data;

			if (hit_eff7)
				rom_we_en <= req.data[2];

			if (hit_77)
				pager_en <= req.data[0];
		end
	end

	//////////////////////////////
	// pager write strobe
	//////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			wr_valid <= 1'b0;
		else
			wr_valid <= hit_f7;
	end

	// data bits are inverted on the atm bus
	always_ff @(posedge fclk)
	begin
		if (hit_f7)
		begin
			wr_win  <= a[15:14];
			wr_rom  <= ~req.data[7];
			wr_page <= ~req.data[`MM_PAGE_W-1:0];
		end
	end

	//////////////////////////////
	// dos rom switch
	//////////////////////////////

	always_comb
	begin
		m1_fetch = req.mreq & req.m1 & req.rd;

		// entry only from 3dxx while rom sits in window 0
		dos_set  = m1_fetch && (a[15:8] == `MM_DOS_PAGE_HI) && win0_rom;

		// any opcode fetch above 3fff leaves dos
		dos_clr  = m1_fetch && (a[15:14] != 2'b00);
	end

	always_comb
	begin
		dos_next = dos_state;
		case (dos_state)
			DOS_OFF:
				if (dos_set)
					dos_next = DOS_ON;
			DOS_ON:
				if (dos_clr)
					dos_next = DOS_OFF;
			default:
				dos_next = DOS_OFF;
		endcase
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			dos_state <= DOS_OFF;
		else
			dos_state <= dos_next;
	end

	//////////////////////////////
	// outputs
	//////////////////////////////

	always_comb
	begin
		cfg.pager_en  = pager_en;
		cfg.p7ffd     = p7ffd;
		cfg.rom_we_en = rom_we_en;
		cfg.dos       = (dos_state == DOS_ON);

		pg_wr.valid   = wr_valid;
		pg_wr.win     = wr_win;
		pg_wr.rom     = wr_rom;
		pg_wr.page    = wr_page;
	end

endmodule

`default_nettype wire

/* logic/memmap_pkg.sv */
`default_nettype none

`include "memmap_settings.svh"

package memmap_pkg;

	//////////////////////////////
	// plain vectors
	//////////////////////////////

	typedef logic [`MM_ADDR_W-1:0] zaddr_t;
	typedef logic [`MM_DATA_W-1:0] zdata_t;
	typedef logic [`MM_PAGE_W-1:0] page_t;

	// page on top, offset below
	typedef logic [`MM_PAGE_W+`MM_OFFS_W-1:0] phys_addr_t;

	typedef logic [$clog2(`MM_WINDOWS)-1:0] win_idx_t;

	//////////////////////////////
	// bundles
	//////////////////////////////

	// one sampled z80 bus cycle, strobes already active high
	typedef struct packed {
		logic   mreq;
		logic   iorq;
		logic   rd;
		logic   wr;
		logic   m1;
		zaddr_t addr;
		zdata_t data;
	} zbus_req_t;

	// strobe to one window pager
	typedef struct packed {
		logic     valid;
		win_idx_t win;
		logic     rom;
		page_t    page;
	} page_wr_t;

	// decoder state seen by the datapath
	typedef struct packed {
		logic   pager_en;
		zdata_t p7ffd;
		logic   rom_we_en;
		logic   dos;
	} map_cfg_t;

	typedef struct packed {
		logic  rom;
		page_t page;
	} win_map_t;

	// mapped memory access
	typedef struct packed {
		logic       valid;
		logic       rom;
		logic       we;
		logic       fetch;
		phys_addr_t addr;
	} mem_acc_t;

	typedef enum logic {
		DOS_OFF,
		DOS_ON
	} dos_state_t;

endpackage

`default_nettype wire

/* logic/memmap_settings.svh */
`ifndef MEMMAP_SETTINGS_SVH
`define MEMMAP_SETTINGS_SVH

//////////////////////////////
// bus and window geometry
//////////////////////////////

`define MM_ADDR_W        16
`define MM_DATA_W        8
`define MM_WINDOWS       4
`define MM_PAGE_W        6
`define MM_OFFS_W        14

//////////////////////////////
// z80 port numbers
//////////////////////////////

// 7ffd is decoded on low byte and a15 only
`define MM_PORT_7FFD_LO  8'hFD
// atm pager ports, a15..a14 pick the window
`define MM_PORT_F7_LO    8'hF7
`define MM_PORT_77_LO    8'h77
`define MM_PORT_EFF7     16'hEFF7

// lock bit inside 7ffd
`define MM_7FFD_LOCK     5

// high byte of the dos entry area
`define MM_DOS_PAGE_HI   8'h3D

// pentagon fallback pages for windows 1 and 2
`define MM_FB_PAGE_WIN1  5
`define MM_FB_PAGE_WIN2  2

`endif
